// File: common/gvp_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// vector program core, shared constants
//////////////////////////////////////////////////////////////////////

package gvp_pkg;

    // program memory geometry
    localparam int num_vectors_n2 = 3;       // slot address bits
    localparam int num_vectors    = 8;       // slots in the program

    // record geometry
    localparam int word_w = 32;              // one record word
    localparam int rec_w  = 512;             // full record, 16 words
    localparam int next_w = 8;               // signed jump width

    // word index of each field inside a record
    localparam int w_addr    = 0;            // target slot, low bits only
    localparam int w_n       = 1;            // point count
    localparam int w_iin     = 2;            // silent steps between points
    localparam int w_options = 3;            // section options, passed through
    localparam int w_nrep    = 4;            // loop repeat count
    localparam int w_next    = 5;            // signed jump, low next_w bits
    localparam int w_dx      = 6;
    localparam int w_dy      = 7;
    localparam int w_dz      = 8;
    localparam int w_du      = 9;
    // words 10 to 14 are spare
    localparam int w_deci    = 15;           // step decimation

    // store_data event codes
    localparam logic [1:0] store_none    = 2'd0;
    localparam logic [1:0] store_data_pt = 2'd1;   // data point reached
    localparam logic [1:0] store_header  = 2'd2;   // vector header loaded

endpackage

`default_nettype wire

// File: common/gvp_vec_if.sv
`timescale 1ns/10ps
`default_nettype none

// current vector fields and loop counter handshake
interface gvp_vec_if;

    logic [gvp_pkg::num_vectors_n2-1:0] pvc;      // program counter

    // fields of slot pvc, combinational
    logic [gvp_pkg::word_w-1:0]         n;
    logic [gvp_pkg::word_w-1:0]         iin;
    logic [gvp_pkg::word_w-1:0]         options;
    logic signed [gvp_pkg::next_w-1:0]  next;
    logic [gvp_pkg::word_w-1:0]         deci;
    logic signed [gvp_pkg::word_w-1:0]  dx;
    logic signed [gvp_pkg::word_w-1:0]  dy;
    logic signed [gvp_pkg::word_w-1:0]  dz;
    logic signed [gvp_pkg::word_w-1:0]  du;

    // per slot repeat counter
    logic [gvp_pkg::word_w-1:0]         loop_cnt;   // repeats left on slot pvc
    logic                               loop_dec;   // strobe, one more pass taken
    logic                               loop_reload; // strobe, loop done, rearm

    modport mem (
        output n, iin, options, next, deci, dx, dy, dz, du, loop_cnt,
        input  pvc, loop_dec, loop_reload
    );

    modport seq (
        output pvc, loop_dec, loop_reload,
        input  n, iin, options, next, deci, loop_cnt
    );

    modport accum (
        input dx, dy, dz, du
    );

endinterface

`default_nettype wire

// File: gvp/gvp_program_mem.sv
`timescale 1ns/10ps
`default_nettype none

// eight vector records plus their loop counters
module gvp_program_mem (
    input  logic                       a_clk,
    input  logic                       reset,
    input  logic                       setvec,       // write strobe
    input  logic [gvp_pkg::rec_w-1:0]  vp_set,       // full record
    gvp_vec_if.mem                     vec
);

    // record storage, no reset
    logic [gvp_pkg::word_w-1:0]        n_q       [gvp_pkg::num_vectors];
    logic [gvp_pkg::word_w-1:0]        iin_q     [gvp_pkg::num_vectors];
    logic [gvp_pkg::word_w-1:0]        options_q [gvp_pkg::num_vectors];
    logic [gvp_pkg::word_w-1:0]        nrep_q    [gvp_pkg::num_vectors];
    logic signed [gvp_pkg::next_w-1:0] next_q    [gvp_pkg::num_vectors];
    logic [gvp_pkg::word_w-1:0]        deci_q    [gvp_pkg::num_vectors];
    logic signed [gvp_pkg::word_w-1:0] dx_q      [gvp_pkg::num_vectors];
    logic signed [gvp_pkg::word_w-1:0] dy_q      [gvp_pkg::num_vectors];
    logic signed [gvp_pkg::word_w-1:0] dz_q      [gvp_pkg::num_vectors];
    logic signed [gvp_pkg::word_w-1:0] du_q      [gvp_pkg::num_vectors];

    logic [gvp_pkg::word_w-1:0]        loop_cnt_q [gvp_pkg::num_vectors];

    logic [gvp_pkg::num_vectors_n2-1:0] wr_addr;
    logic [gvp_pkg::word_w-1:0]         wr_nrep;

    ////////////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////////////

    // slot select sits in the low bits of word 0
    assign wr_addr = vp_set[gvp_pkg::w_addr*gvp_pkg::word_w +: gvp_pkg::num_vectors_n2];
    assign wr_nrep = vp_set[gvp_pkg::w_nrep*gvp_pkg::word_w +: gvp_pkg::word_w];

    always_ff @(posedge a_clk)
    begin
        if (setvec)   // any edge, reset or running
        begin
            n_q[wr_addr]       <= vp_set[gvp_pkg::w_n*gvp_pkg::word_w +: gvp_pkg::word_w];
            iin_q[wr_addr]     <= vp_set[gvp_pkg::w_iin*gvp_pkg::word_w +: gvp_pkg::word_w];
            options_q[wr_addr] <= vp_set[gvp_pkg::w_options*gvp_pkg::word_w +: gvp_pkg::word_w];
            nrep_q[wr_addr]    <= wr_nrep;
            next_q[wr_addr]    <= vp_set[gvp_pkg::w_next*gvp_pkg::word_w +: gvp_pkg::next_w];
            deci_q[wr_addr]    <= vp_set[gvp_pkg::w_deci*gvp_pkg::word_w +: gvp_pkg::word_w];
            dx_q[wr_addr]      <= vp_set[gvp_pkg::w_dx*gvp_pkg::word_w +: gvp_pkg::word_w];
            dy_q[wr_addr]      <= vp_set[gvp_pkg::w_dy*gvp_pkg::word_w +: gvp_pkg::word_w];
            dz_q[wr_addr]      <= vp_set[gvp_pkg::w_dz*gvp_pkg::word_w +: gvp_pkg::word_w];
            du_q[wr_addr]      <= vp_set[gvp_pkg::w_du*gvp_pkg::word_w +: gvp_pkg::word_w];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // loop counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            // rearm every slot so a rerun repeats the same loops
            for (int k = 0; k < gvp_pkg::num_vectors; k++)
            begin
                loop_cnt_q[k] <= nrep_q[k];
            end
        end
        else if (vec.loop_dec)
        begin
            loop_cnt_q[vec.pvc] <= loop_cnt_q[vec.pvc] - gvp_pkg::word_w'(1);
        end
        else if (vec.loop_reload)
        begin
            loop_cnt_q[vec.pvc] <= nrep_q[vec.pvc];   // ready for the next visit
        end

        // a fresh record always wins over the counter update
        if (setvec)
        begin
            loop_cnt_q[wr_addr] <= wr_nrep;
        end
    end

    // read port, slot pvc
    assign vec.n        = n_q[vec.pvc];
    assign vec.iin      = iin_q[vec.pvc];
    assign vec.options  = options_q[vec.pvc];
    assign vec.next     = next_q[vec.pvc];
    assign vec.deci     = deci_q[vec.pvc];
    assign vec.dx       = dx_q[vec.pvc];
    assign vec.dy       = dy_q[vec.pvc];
    assign vec.dz       = dz_q[vec.pvc];
    assign vec.du       = du_q[vec.pvc];
    assign vec.loop_cnt = loop_cnt_q[vec.pvc];

endmodule

`default_nettype wire

// File: gvp/gvp_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

// step pacing and program walk
module gvp_sequencer (
    input  logic                        a_clk,
    input  logic                        reset,
    input  logic                        pause,        // stalls at data points only
    gvp_vec_if.seq                      vec,
    output logic                        acc_clear,
    output logic                        acc_add,
    output logic [gvp_pkg::word_w-1:0]  options,
    output logic [gvp_pkg::word_w-1:0]  section,
    output logic [gvp_pkg::word_w-1:0]  point_count,
    output logic [1:0]                  store_data,
    output logic                        finished,
    output logic                        hold
);

    // decimation
    logic [gvp_pkg::word_w-1:0] deci_q;          // of the last loaded vector
    logic [gvp_pkg::word_w-1:0] tick_cnt_q;
    logic                       tick;

    // program state
    logic                       load_q;          // next step loads vector pvc
    logic                       finished_q;
    logic                       hold_q;          // last step was a pause stall
    logic [gvp_pkg::num_vectors_n2-1:0] pvc_q;
    logic [gvp_pkg::word_w-1:0] pt_q;            // points left after this one
    logic [gvp_pkg::word_w-1:0] ii_q;            // silent steps left
    logic [gvp_pkg::word_w-1:0] sec_q;
    logic [gvp_pkg::word_w-1:0] options_q;
    logic [1:0]                 store_q;

    // step decode
    logic load_step;
    logic run_step;
    logic ii_busy;
    logic point_step;
    logic stall_step;
    logic last_point;
    logic end_of_prog;

    ////////////////////////////////////////////////////////////////////
    // step decode
    ////////////////////////////////////////////////////////////////////

    assign tick        = (tick_cnt_q == '0);     // first cycle out of reset too
    assign load_step   = tick & load_q & ~finished_q;
    assign run_step    = tick & ~load_q & ~finished_q;
    assign ii_busy     = (ii_q != '0);
    assign point_step  = run_step & ~ii_busy & ~pause;
    assign stall_step  = run_step & ~ii_busy & pause;
    assign last_point  = (pt_q == '0);
    assign end_of_prog = (vec.n == '0);          // zero length vector ends it

    // add on silent steps and on data points, never while stalled
    assign acc_add   = run_step & (ii_busy | ~pause);
    assign acc_clear = reset;                    // positions follow the reset level

    // loop counter strobes act on slot pvc before it moves
    assign vec.loop_dec    = point_step & last_point & (vec.loop_cnt != '0);
    assign vec.loop_reload = point_step & last_point & (vec.loop_cnt == '0);

    ////////////////////////////////////////////////////////////////////
    // decimation tick
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            tick_cnt_q <= '0;
            deci_q     <= '0;
        end
        else if (tick)
        begin
            if (load_step && !end_of_prog)
            begin
                tick_cnt_q <= vec.deci;    // new vector paces from here on
                deci_q     <= vec.deci;
            end
            else
            begin
                tick_cnt_q <= deci_q;
            end
        end
        else
        begin
            tick_cnt_q <= tick_cnt_q - gvp_pkg::word_w'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // program walk
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            load_q     <= 1'b1;     // arm the first load
            finished_q <= 1'b0;
            hold_q     <= 1'b0;
            pvc_q      <= '0;
            pt_q       <= '0;
            ii_q       <= '0;
            sec_q      <= '0;
            store_q    <= gvp_pkg::store_none;
        end
        else
        begin
            store_q <= gvp_pkg::store_none;   // pulses last one cycle
            if (tick)
            begin
                hold_q <= stall_step;
            end

            if (load_step)
            begin
                store_q <= gvp_pkg::store_header;
                load_q  <= 1'b0;
                if (end_of_prog)
                begin
                    finished_q <= 1'b1;       // idle until reset
                end
                else
                begin
                    pt_q <= vec.n;
                    ii_q <= vec.iin;
                end
            end
            else if (run_step && ii_busy)
            begin
                ii_q <= ii_q - gvp_pkg::word_w'(1);   // silent step
            end
            else if (point_step)
            begin
                store_q <= gvp_pkg::store_data_pt;
                if (!last_point)
                begin
                    pt_q <= pt_q - gvp_pkg::word_w'(1);
                    ii_q <= vec.iin;
                end
                else
                begin
                    sec_q  <= sec_q + gvp_pkg::word_w'(1);   // vector pass done
                    load_q <= 1'b1;
                    if (vec.loop_cnt != '0)
                    begin
                        // signed jump, wraps inside the program
                        pvc_q <= pvc_q + vec.next[gvp_pkg::num_vectors_n2-1:0];
                    end
                    else
                    begin
                        pvc_q <= pvc_q + gvp_pkg::num_vectors_n2'(1);
                    end
                end
            end
        end
    end

    // header shows the options of the vector being loaded
    always_ff @(posedge a_clk)
    begin
        if (load_step)
        begin
            options_q <= vec.options;
        end
    end

    assign vec.pvc     = pvc_q;
    assign options     = options_q;
    assign section     = sec_q;
    assign point_count = pt_q;
    assign store_data  = store_q;
    assign finished    = finished_q;
    assign hold        = hold_q & pause;   // drops as soon as pause is released

endmodule

`default_nettype wire

// File: gvp/gvp_vector_accum.sv
`timescale 1ns/10ps
`default_nettype none

// x y z u position registers
module gvp_vector_accum (
    input  logic                               a_clk,
    input  logic                               acc_clear,
    input  logic                               acc_add,
    gvp_vec_if.accum                           vec,
    output logic signed [gvp_pkg::word_w-1:0]  x,
    output logic signed [gvp_pkg::word_w-1:0]  y,
    output logic signed [gvp_pkg::word_w-1:0]  z,
    output logic signed [gvp_pkg::word_w-1:0]  u
);

    // plain 32 bit wrap, no saturation
    always_ff @(posedge a_clk)
    begin
        if (acc_clear)
        begin
            x <= '0;
            y <= '0;
            z <= '0;
            u <= '0;
        end
        else if (acc_add)
        begin
            x <= x + vec.dx;
            y <= y + vec.dy;
            z <= z + vec.dz;
            u <= u + vec.du;
        end
        // else frozen, also during a pause stall
    end

endmodule

`default_nettype wire

// File: design/gvp_top.sv
`timescale 1ns/10ps
`default_nettype none

// general vector program core, top level
module gvp_top (
    input  logic                               a_clk,
    input  logic                               reset,
    input  logic                               pause,
    input  logic                               setvec,
    input  logic [gvp_pkg::rec_w-1:0]          vp_set,
    output logic signed [gvp_pkg::word_w-1:0]  x,
    output logic signed [gvp_pkg::word_w-1:0]  y,
    output logic signed [gvp_pkg::word_w-1:0]  z,
    output logic signed [gvp_pkg::word_w-1:0]  u,
    output logic [gvp_pkg::word_w-1:0]         options,
    output logic [gvp_pkg::word_w-1:0]         section,
    output logic [gvp_pkg::word_w-1:0]         point_count,
    output logic [1:0]                         store_data,
    output logic                               finished,
    output logic                               hold
);

    logic acc_clear;
    logic acc_add;

    gvp_vec_if vec_bus ();   // current vector between the three blocks

    gvp_program_mem u_program_mem (
        .a_clk  (a_clk),
        .reset  (reset),
        .setvec (setvec),
        .vp_set (vp_set),
        .vec    (vec_bus.mem)
    );

    gvp_sequencer u_sequencer (
        .a_clk       (a_clk),
        .reset       (reset),
        .pause       (pause),
        .vec         (vec_bus.seq),
        .acc_clear   (acc_clear),
        .acc_add     (acc_add),
        .options     (options),
        .section     (section),
        .point_count (point_count),
        .store_data  (store_data),
        .finished    (finished),
        .hold        (hold)
    );

    gvp_vector_accum u_vector_accum (
        .a_clk     (a_clk),
        .acc_clear (acc_clear),
        .acc_add   (acc_add),
        .vec       (vec_bus.accum),
        .x         (x),
        .y         (y),
        .z         (z),
        .u         (u)
    );

endmodule

`default_nettype wire

// File: dv/tb_gvp.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gvp;

    localparam int num_programs = 4;
    localparam int max_deci     = 3;
    localparam int idle_cycles  = 20;     // quiet window after finished
    localparam int pause_factor = 4;      // slack for random stalls
    localparam int stall_cycles = 24;     // reaches the first data point at any deci

    logic                              a_clk;
    logic                              reset;
    logic                              pause;
    logic                              setvec;
    logic [gvp_pkg::rec_w-1:0]         vp_set;
    logic signed [gvp_pkg::word_w-1:0] x;
    logic signed [gvp_pkg::word_w-1:0] y;
    logic signed [gvp_pkg::word_w-1:0] z;
    logic signed [gvp_pkg::word_w-1:0] u;
    logic [gvp_pkg::word_w-1:0]        options;
    logic [gvp_pkg::word_w-1:0]        section;
    logic [gvp_pkg::word_w-1:0]        point_count;
    logic [1:0]                        store_data;
    logic                              finished;
    logic                              hold;

    // current random program
    int          prog_len;
    logic [31:0] p_n [8];
    logic [31:0] p_iin [8];
    logic [31:0] p_opt [8];
    logic [31:0] p_nrep [8];
    logic [31:0] p_deci [8];
    logic [31:0] p_dx [8];
    logic [31:0] p_dy [8];
    logic [31:0] p_dz [8];
    logic [31:0] p_du [8];
    int          p_next [8];                // backward or zero jump

    // model state
    int          m_pvc;
    logic [31:0] m_sec;
    logic [31:0] m_pt;                      // point counter
    logic [31:0] m_x;                       // wrap like the DUT
    logic [31:0] m_y;
    logic [31:0] m_z;
    logic [31:0] m_u;
    logic [31:0] m_lc [8];

    // expected events in order
    logic [31:0] q_code [$];
    logic [31:0] q_opt [$];
    logic [31:0] q_sec [$];
    logic [31:0] q_fin [$];
    logic [31:0] q_pt [$];
    logic [31:0] q_x [$];
    logic [31:0] q_y [$];
    logic [31:0] q_z [$];
    logic [31:0] q_u [$];

    integer seed;
    int     cycle_cnt;
    int     cycle_limit;
    bit     checking;
    string  run_name;

    gvp_top gvp_top_i (
        .a_clk       (a_clk),
        .reset       (reset),
        .pause       (pause),
        .setvec      (setvec),
        .vp_set      (vp_set),
        .x           (x),
        .y           (y),
        .z           (z),
        .u           (u),
        .options     (options),
        .section     (section),
        .point_count (point_count),
        .store_data  (store_data),
        .finished    (finished),
        .hold        (hold)
    );

    initial a_clk = 1'b0;
    always #50 a_clk = ~a_clk;    // 100 ns period

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s %s expected %h actual %h", run_name, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic int unsigned rand_range(input int unsigned span);
        int unsigned r;
        r = $random(seed);
        return r % span;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // program generation and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic gen_program();
        prog_len = 2 + rand_range(6);       // last slot is the stop vector
        for (int k = 0; k < prog_len; k++)
        begin
            p_n[k]    = (k == prog_len - 1) ? 32'd0 : 32'(1 + rand_range(3));
            p_iin[k]  = rand_range(4);
            p_nrep[k] = rand_range(3);
            p_deci[k] = rand_range(max_deci + 1);
            p_opt[k]  = $random(seed);
            p_next[k] = -int'(rand_range(k + 1));   // stays inside the program
            p_dx[k]   = $random(seed);
            p_dy[k]   = $random(seed);
            p_dz[k]   = $random(seed);
            p_du[k]   = $random(seed);
        end
    endtask

    task automatic push_event(input logic [1:0] code, input logic fin);
        q_code.push_back(32'(code));
        q_opt.push_back(p_opt[m_pvc]);
        q_sec.push_back(m_sec);
        q_fin.push_back(32'(fin));
        q_pt.push_back(m_pt);
        q_x.push_back(m_x);
        q_y.push_back(m_y);
        q_z.push_back(m_z);
        q_u.push_back(m_u);
    endtask

    task automatic model_add();
        m_x = m_x + p_dx[m_pvc];
        m_y = m_y + p_dy[m_pvc];
        m_z = m_z + p_dz[m_pvc];
        m_u = m_u + p_du[m_pvc];
    endtask

    // walks the program once and counts the steps
    task automatic build_expected(output int steps);
        bit done;
        done  = 1'b0;
        steps = 0;
        m_pvc = 0;
        m_sec = '0;
        m_pt  = '0;
        {m_x, m_y, m_z, m_u} = '0;
        for (int k = 0; k < prog_len; k++)
            m_lc[k] = p_nrep[k];
        while (!done)
        begin
            steps++;                                          // load step
            if (p_n[m_pvc] != 0)
                m_pt = p_n[m_pvc];
            push_event(gvp_pkg::store_header, p_n[m_pvc] == 0);
            if (p_n[m_pvc] == 0)
                done = 1'b1;
            else
            begin
                for (int p = int'(p_n[m_pvc]); p >= 0; p--)  // n + 1 points
                begin
                    for (int i = 0; i < int'(p_iin[m_pvc]); i++)
                    begin
                        model_add();                         // silent step
                        steps++;
                    end
                    model_add();
                    steps++;
                    if (m_pt != 0)
                        m_pt = m_pt - 1;
                    else
                        m_sec = m_sec + 1;
                    push_event(gvp_pkg::store_data_pt, 1'b0);
                end
                if (m_lc[m_pvc] != 0)
                begin
                    m_lc[m_pvc] = m_lc[m_pvc] - 1;
                    m_pvc = m_pvc + p_next[m_pvc];
                end
                else
                begin
                    m_lc[m_pvc] = p_nrep[m_pvc];
                    m_pvc = m_pvc + 1;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic assert_reset();
        @(negedge a_clk);
        reset  = 1'b1;
        pause  = 1'b0;
        setvec = 1'b0;
        repeat (2) @(negedge a_clk);
        check_value("reset finished", 32'd0, 32'(finished));
        check_value("reset section", 32'd0, section);
        check_value("reset x", 32'd0, x);
        check_value("reset y", 32'd0, y);
        check_value("reset z", 32'd0, z);
        check_value("reset u", 32'd0, u);
    endtask

    // one record per cycle while reset is high
    task automatic write_program();
        for (int k = 0; k < prog_len; k++)
        begin
            vp_set = '0;
            vp_set[gvp_pkg::w_addr*32 +: 32]    = k;
            vp_set[gvp_pkg::w_n*32 +: 32]       = p_n[k];
            vp_set[gvp_pkg::w_iin*32 +: 32]     = p_iin[k];
            vp_set[gvp_pkg::w_options*32 +: 32] = p_opt[k];
            vp_set[gvp_pkg::w_nrep*32 +: 32]    = p_nrep[k];
            vp_set[gvp_pkg::w_next*32 +: 32]    = 32'(p_next[k]);
            vp_set[gvp_pkg::w_dx*32 +: 32]      = p_dx[k];
            vp_set[gvp_pkg::w_dy*32 +: 32]      = p_dy[k];
            vp_set[gvp_pkg::w_dz*32 +: 32]      = p_dz[k];
            vp_set[gvp_pkg::w_du*32 +: 32]      = p_du[k];
            vp_set[gvp_pkg::w_deci*32 +: 32]    = p_deci[k];
            setvec = 1'b1;
            @(negedge a_clk);
        end
        setvec = 1'b0;
    endtask

    task automatic run_program(input bit with_pause);
        int steps;
        build_expected(steps);
        cycle_limit = steps * (max_deci + 1) * pause_factor + stall_cycles + 100;
        cycle_cnt   = 0;
        checking    = 1'b1;
        reset       = 1'b0;
        if (with_pause)
        begin
            // first vector has points, so the core must stall at its first one
            pause = 1'b1;
            repeat (stall_cycles) @(negedge a_clk);
            check_value("hold in stall", 32'd1, 32'(hold));
        end
        while (!finished)
        begin
            @(negedge a_clk);
            pause = with_pause ? (rand_range(3) == 0) : 1'b0;
        end
        pause = 1'b0;
        repeat (idle_cycles) @(negedge a_clk);    // any late pulse is flagged
        check_value("events left", 32'd0, q_code.size());
        check_value("finished held", 32'd1, 32'(finished));
        checking = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // event checker, hold check and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge a_clk)
    begin
        if (checking && store_data != gvp_pkg::store_none)
        begin
            if (q_code.size() == 0)
            begin
                $display("%s store_data pulse after the last expected event", run_name);
                abort_run();
            end
            else
            begin
                check_value("code", q_code.pop_front(), 32'(store_data));
                check_value("options", q_opt.pop_front(), options);
                check_value("section", q_sec.pop_front(), section);
                check_value("finished", q_fin.pop_front(), 32'(finished));
                check_value("point_count", q_pt.pop_front(), point_count);
                check_value("x", q_x.pop_front(), x);
                check_value("y", q_y.pop_front(), y);
                check_value("z", q_z.pop_front(), z);
                check_value("u", q_u.pop_front(), u);
            end
        end
        if (checking && hold && !pause)
        begin
            $display("%s hold is high while pause is low", run_name);
            abort_run();
        end
        if (checking && hold && store_data != gvp_pkg::store_none)
        begin
            $display("%s hold is high in a cycle with a store_data pulse", run_name);
            abort_run();
        end
        if (checking)
        begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > cycle_limit)
            begin
                $display("%s timeout, program did not finish in %0d cycles", run_name,
                         cycle_limit);
                abort_run();
            end
        end
    end

    initial
    begin
        seed     = 32'hbc16;
        reset    = 1'b1;
        pause    = 1'b0;
        setvec   = 1'b0;
        vp_set   = '0;
        checking = 1'b0;
        for (int prog = 0; prog < num_programs; prog++)
        begin
            gen_program();
            assert_reset();
            write_program();
            run_name = $sformatf("prog %0d plain", prog);
            run_program(1'b0);
            assert_reset();                          // rerun with the loop counters rearmed
            run_name = $sformatf("prog %0d pause", prog);
            run_program(1'b1);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
common/gvp_pkg.sv
common/gvp_vec_if.sv
gvp/gvp_program_mem.sv
gvp/gvp_sequencer.sv
gvp/gvp_vector_accum.sv
design/gvp_top.sv
dv/tb_gvp.sv

// File: Bender.yml
package:
  name: gvp

sources:
  - common/gvp_pkg.sv
  - common/gvp_vec_if.sv
  - gvp/gvp_program_mem.sv
  - gvp/gvp_sequencer.sv
  - gvp/gvp_vector_accum.sv
  - design/gvp_top.sv
  - target: simulation
    files:
      - dv/tb_gvp.sv
